// File: filelist.f
hw/DebugPkg.sv
hw/MemReqIf.sv
hw/JtagPort.sv
hw/McuRunControl.sv
hw/DebugMemory.sv
hw/DebugSubsystem.sv
verif/DebugChecker.sv
verif/tb_DebugSubsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the DebugSubsystem testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_DebugSubsystem
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" --Mdir "$BUILD_DIR" -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The testbench prints the pass line only when every check held.
if grep -q "^Test OK$" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation did not pass, see $LOG"
exit 1

// File: verif/tb_DebugSubsystem.sv
`timescale 1ns/1ns

module tb_DebugSubsystem;

    // Boot runs long enough for the first status read to land inside it.
    localparam int BOOT_CYCLES      = 300;
    localparam int MEM_DEPTH        = 256;
    // Clocks per TCK phase.
    localparam int TCK_HALF         = 8;
    // Watchdog budget per table entry.
    localparam int CLOCKS_PER_ENTRY = 2000;

    // Operation kinds of the stimulus table.
    typedef enum logic [3:0] {
        OP_STATUS, OP_BOOTWAIT, OP_CMD, OP_JWRITE,
        OP_JREAD, OP_CWRITE, OP_CREAD, OP_LOCK
    } opKind_e;

    // One table row.
    typedef struct packed {
        opKind_e          kind;
        DebugPkg::instr_t instr;
        DebugPkg::addr_t  addr;
        logic [1:0]       slot;
        logic             expBooted;
        logic             expPaused;
        logic [2:0]       expLocks;  // {storeEn, scanShift, scanEn}
    } stimEntry_t;

    logic            clk;
    logic            reset;

    // JTAG pins.
    logic            tckPin;
    logic            tmsPin;
    logic            tdiPin;
    logic            tdo;

    // Core port.
    logic            coreEn;
    logic            coreWr;
    DebugPkg::addr_t coreAddr;
    DebugPkg::data_t coreWrData;
    DebugPkg::data_t coreRdData;
    logic            coreReady;

    // Status and lock outputs.
    logic            isBooted;
    logic            isPaused;
    logic            storeEn;
    logic            scanEn;
    logic            scanShift;

    stimEntry_t      stim [$];
    // Random data words, picked by the slot field.
    DebugPkg::data_t rnd [4];
    // Clocks since reset was released.
    int              cycleCnt;

    // --------------------
    // Clock and cycle count.
    // --------------------
    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (reset) begin
            cycleCnt <= 0;
        end else begin
            cycleCnt <= cycleCnt + 1;
        end
    end

    DebugSubsystem #(
        .BOOT_CYCLES (BOOT_CYCLES),
        .MEM_DEPTH   (MEM_DEPTH)
    ) dut_i (
        .i_clk        (clk),
        .i_reset      (reset),
        .i_TCK        (tckPin),
        .i_TMS        (tmsPin),
        .i_TDI        (tdiPin),
        .o_TDO        (tdo),
        .i_coreEn     (coreEn),
        .i_coreWr     (coreWr),
        .i_coreAddr   (coreAddr),
        .i_coreWrData (coreWrData),
        .o_coreRdData (coreRdData),
        .o_coreReady  (coreReady),
        .o_isBooted   (isBooted),
        .o_isPaused   (isPaused),
        .o_storeEn    (storeEn),
        .o_scanEn     (scanEn),
        .o_scanShift  (scanShift)
    );

    DebugChecker checker_i (
        .i_clk       (clk),
        .i_reset     (reset),
        .i_isBooted  (isBooted),
        .i_isPaused  (isPaused),
        .i_coreReady (coreReady),
        .i_scanEn    (scanEn),
        .i_scanShift (scanShift),
        .i_storeEn   (storeEn)
    );

    // --------------------
    // Pin-level helpers.
    // --------------------
    // Ends 1 ns after a rising clock edge.
    task automatic waitClocks(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // One full TCK period, TMS and TDI change with the falling edge.
    task automatic tckPulse(input logic tms, input logic tdi, output logic tdoBit);
        tckPin = 1'b0;
        tmsPin = tms;
        tdiPin = tdi;
        waitClocks(TCK_HALF);
        // TDO settled long ago, sample right before the rising edge.
        tdoBit = tdo;
        tckPin = 1'b1;
        waitClocks(TCK_HALF);
    endtask

    // IDLE to UPDATE and back, returns the status byte.
    task automatic shiftInstr(input DebugPkg::instr_t code, output DebugPkg::instr_t readOut);
        logic bitOut;
        tckPulse(1'b0, 1'b0, bitOut);
        // Status is captured on the edge into ISHFT.
        tckPulse(1'b0, 1'b0, bitOut);
        for (int i = 7; i >= 0; i--) begin
            tckPulse(i == 0, code[i], bitOut);
            readOut[i] = bitOut;
        end
        // UPDATE falls back to IDLE.
        tckPulse(1'b1, 1'b0, bitOut);
    endtask

    // IDLE through DSEL into DSHFT, 16 bits MSB first, out to IDLE.
    task automatic shiftData(input DebugPkg::data_t din, output DebugPkg::data_t dout);
        logic bitOut;
        tckPulse(1'b0, 1'b0, bitOut);
        tckPulse(1'b1, 1'b0, bitOut);
        tckPulse(1'b0, 1'b0, bitOut);
        for (int i = 15; i >= 0; i--) begin
            tckPulse(i == 0, din[i], bitOut);
            dout[i] = bitOut;
        end
    endtask

    task automatic setAddress(input DebugPkg::addr_t addr);
        DebugPkg::data_t  dummyData;
        DebugPkg::instr_t dummyInstr;
        shiftData(addr, dummyData);
        shiftInstr(DebugPkg::CMD_SETADDR, dummyInstr);
    endtask

    // --------------------
    // Core port helpers.
    // --------------------
    task automatic coreWrite(input DebugPkg::addr_t addr, input DebugPkg::data_t data);
        // Ready low is the only back-pressure.
        while (!coreReady) begin
            waitClocks(1);
        end
        coreEn     = 1'b1;
        coreWr     = 1'b1;
        coreAddr   = addr;
        coreWrData = data;
        waitClocks(1);
        coreEn = 1'b0;
        coreWr = 1'b0;
    endtask

    task automatic coreRead(input DebugPkg::addr_t addr, output DebugPkg::data_t data);
        while (!coreReady) begin
            waitClocks(1);
        end
        coreEn   = 1'b1;
        coreWr   = 1'b0;
        coreAddr = addr;
        waitClocks(1);
        coreEn = 1'b0;
        // Registered on the request edge.
        data = coreRdData;
    endtask

    // --------------------
    // Stimulus table.
    // --------------------
    task automatic addEntry(input opKind_e kind, input DebugPkg::instr_t instr,
                            input DebugPkg::addr_t addr, input logic [1:0] slot,
                            input logic booted, input logic paused, input logic [2:0] locks);
        stim.push_back(stimEntry_t'{kind, instr, addr, slot, booted, paused, locks});
    endtask

    task automatic buildTable();
        // Status and boot.
        addEntry(OP_STATUS,   DebugPkg::CMD_NOP,   16'h0, 2'd0, 1'b0, 1'b0, 3'b000);
        addEntry(OP_BOOTWAIT, DebugPkg::CMD_NOP,   16'h0, 2'd0, 1'b1, 1'b0, 3'b000);
        addEntry(OP_STATUS,   DebugPkg::CMD_NOP,   16'h0, 2'd0, 1'b1, 1'b0, 3'b000);
        // Run and pause.
        addEntry(OP_CMD,      DebugPkg::CMD_PAUSE, 16'h0, 2'd0, 1'b1, 1'b1, 3'b000);
        addEntry(OP_STATUS,   DebugPkg::CMD_NOP,   16'h0, 2'd0, 1'b1, 1'b1, 3'b000);
        addEntry(OP_CMD,      DebugPkg::CMD_RUN,   16'h0, 2'd0, 1'b1, 1'b0, 3'b000);
        addEntry(OP_STATUS,   DebugPkg::CMD_NOP,   16'h0, 2'd0, 1'b1, 1'b0, 3'b000);
        // JTAG write, core read.
        addEntry(OP_CMD,      DebugPkg::CMD_PAUSE, 16'h0, 2'd0, 1'b1, 1'b1, 3'b000);
        addEntry(OP_JWRITE,   DebugPkg::CMD_NOP,  16'h12, 2'd0, 1'b1, 1'b1, 3'b000);
        addEntry(OP_CMD,      DebugPkg::CMD_RUN,   16'h0, 2'd0, 1'b1, 1'b0, 3'b000);
        addEntry(OP_CREAD,    DebugPkg::CMD_NOP,  16'h12, 2'd0, 1'b1, 1'b0, 3'b000);
        // Core write, JTAG read, then once more through the wrapped address.
        addEntry(OP_CWRITE,   DebugPkg::CMD_NOP,  16'h33, 2'd1, 1'b1, 1'b0, 3'b000);
        addEntry(OP_CMD,      DebugPkg::CMD_PAUSE, 16'h0, 2'd0, 1'b1, 1'b1, 3'b000);
        addEntry(OP_JREAD,    DebugPkg::CMD_NOP,  16'h33, 2'd1, 1'b1, 1'b1, 3'b000);
        addEntry(OP_JREAD,    DebugPkg::CMD_NOP, 16'h133, 2'd1, 1'b1, 1'b1, 3'b000);
        // Gating, a write while running must not land.
        addEntry(OP_CMD,      DebugPkg::CMD_RUN,   16'h0, 2'd0, 1'b1, 1'b0, 3'b000);
        addEntry(OP_JWRITE,   DebugPkg::CMD_NOP,  16'h33, 2'd2, 1'b1, 1'b0, 3'b000);
        addEntry(OP_CREAD,    DebugPkg::CMD_NOP,  16'h33, 2'd1, 1'b1, 1'b0, 3'b000);
        addEntry(OP_CMD,      8'h08,               16'h0, 2'd0, 1'b1, 1'b0, 3'b000);
        addEntry(OP_CMD,      8'hFF,               16'h0, 2'd0, 1'b1, 1'b0, 3'b000);
        addEntry(OP_STATUS,   DebugPkg::CMD_NOP,   16'h0, 2'd0, 1'b1, 1'b0, 3'b000);
        addEntry(OP_CREAD,    DebugPkg::CMD_NOP,  16'h33, 2'd1, 1'b1, 1'b0, 3'b000);
        // Locks.
        addEntry(OP_CMD,      DebugPkg::CMD_PAUSE, 16'h0, 2'd0, 1'b1, 1'b1, 3'b000);
        addEntry(OP_LOCK,     DebugPkg::CMD_BSCAN, 16'h0, 2'd0, 1'b1, 1'b1, 3'b011);
        addEntry(OP_LOCK,     DebugPkg::CMD_STORE, 16'h0, 2'd0, 1'b1, 1'b1, 3'b100);
        addEntry(OP_LOCK,     DebugPkg::CMD_NOP,   16'h0, 2'd0, 1'b1, 1'b1, 3'b000);
    endtask

    // Applies one row, then checks the status ports against it.
    task automatic runEntry(input stimEntry_t e);
        DebugPkg::instr_t instrOut;
        DebugPkg::data_t  dataOut;
        case (e.kind)
            OP_STATUS: begin
                shiftInstr(e.instr, instrOut);
                // Paused sits above booted.
                checker_i.checkValue("TDO status", {14'b0, e.expPaused, e.expBooted},
                                     {8'b0, instrOut});
            end
            OP_BOOTWAIT: begin
                while (cycleCnt < BOOT_CYCLES - 1) begin
                    waitClocks(1);
                end
                // One cycle short of the count, still booting.
                checker_i.checkPorts(1'b0, 1'b0);
                waitClocks(1);
            end
            OP_CMD: begin
                shiftInstr(e.instr, instrOut);
            end
            OP_JWRITE: begin
                setAddress(e.addr);
                shiftData(rnd[e.slot], dataOut);
                shiftInstr(DebugPkg::CMD_WRMEM, instrOut);
            end
            OP_JREAD: begin
                setAddress(e.addr);
                shiftInstr(DebugPkg::CMD_RDMEM, instrOut);
                shiftData(16'h0000, dataOut);
                checker_i.checkValue("TDO data", rnd[e.slot], dataOut);
            end
            OP_CWRITE: begin
                coreWrite(e.addr, rnd[e.slot]);
            end
            OP_CREAD: begin
                coreRead(e.addr, dataOut);
                checker_i.checkValue("o_coreRdData", rnd[e.slot], dataOut);
            end
            OP_LOCK: begin
                shiftInstr(e.instr, instrOut);
                // Shift-time enables only show inside DSHFT.
                checker_i.markLocks();
                shiftData(16'h0000, dataOut);
                checker_i.checkLocks(e.expLocks);
            end
            default: begin
                checker_i.noteFailure("stimulus table holds an unknown operation kind");
            end
        endcase
        checker_i.checkPorts(e.expBooted, e.expPaused);
    endtask

    // --------------------
    // Main sequence.
    // --------------------
    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        tckPin     = 1'b0;
        tmsPin     = 1'b0;
        tdiPin     = 1'b0;
        coreEn     = 1'b0;
        coreWr     = 1'b0;
        coreAddr   = '0;
        coreWrData = '0;
        void'($urandom(32'hb699));
        for (int i = 0; i < 4; i++) begin
            rnd[i] = 16'($urandom());
        end
        buildTable();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        foreach (stim[i]) begin
            runEntry(stim[i]);
            checker_i.endTest(i, stim[i].kind.name());
        end
        checker_i.report();
        if (checker_i.totalFails() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog, the table is built at time zero.
    initial begin
        #1;
        repeat (stim.size() * CLOCKS_PER_ENTRY) @(posedge clk);
        $display("Watchdog expired after %0d clocks before the table finished",
                 stim.size() * CLOCKS_PER_ENTRY);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: verif/DebugChecker.sv
`timescale 1ns/1ns

module DebugChecker (
    input logic i_clk,
    input logic i_reset,
    // DUT status ports.
    input logic i_isBooted,
    input logic i_isPaused,
    input logic i_coreReady,
    // DUT lock ports.
    input logic i_scanEn,
    input logic i_scanShift,
    input logic i_storeEn
);

    // Totals over the run.
    int failCount   = 0;
    int checkCount  = 0;
    int testCount   = 0;
    // Failures inside the current entry.
    int testFails   = 0;
    // Mismatches seen by the per-cycle monitor.
    int readyErrors = 0;

    // Cycles with each shift-time enable high.
    int scanShiftCycles = 0;
    int storeCycles     = 0;
    // Counts taken when a lock window opens.
    int scanShiftMark   = 0;
    int storeMark       = 0;

    // --------------------
    // Port monitors.
    // --------------------
    always @(posedge i_clk) begin
        if (i_scanShift) begin
            scanShiftCycles <= scanShiftCycles + 1;
        end
        if (i_storeEn) begin
            storeCycles <= storeCycles + 1;
        end
    end

    // Core is ready exactly while booted and running.
    always @(posedge i_clk) begin
        if (!i_reset && (i_coreReady !== (i_isBooted && !i_isPaused))) begin
            $display("FAIL o_coreReady exp %h got %h at %0t",
                     i_isBooted && !i_isPaused, i_coreReady, $time);
            readyErrors <= readyErrors + 1;
        end
    end

    // --------------------
    // Comparisons.
    // --------------------
    task automatic checkValue(input string name, input logic [15:0] expVal,
                              input logic [15:0] gotVal);
        checkCount++;
        if (gotVal !== expVal) begin
            $display("FAIL %s exp %h got %h", name, expVal, gotVal);
            failCount++;
            testFails++;
        end
    endtask

    // Failures that carry no value.
    task automatic noteFailure(input string what);
        $display("Error: %s", what);
        failCount++;
        testFails++;
    endtask

    // Samples the status ports directly.
    task automatic checkPorts(input logic expBooted, input logic expPaused);
        checkValue("o_isBooted", 16'(expBooted), 16'(i_isBooted));
        checkValue("o_isPaused", 16'(expPaused), 16'(i_isPaused));
        checkValue("o_coreReady", 16'(expBooted & ~expPaused), 16'(i_coreReady));
    endtask

    task automatic markLocks();
        scanShiftMark = scanShiftCycles;
        storeMark     = storeCycles;
    endtask

    // Expected bits are {storeEn, scanShift, scanEn}.
    task automatic checkLocks(input logic [2:0] expLocks);
        checkValue("o_scanEn", 16'(expLocks[0]), 16'(i_scanEn));
        checkValue("o_scanShift", 16'(expLocks[1]), 16'(scanShiftCycles != scanShiftMark));
        checkValue("o_storeEn", 16'(expLocks[2]), 16'(storeCycles != storeMark));
    endtask

    // --------------------
    // Reporting.
    // --------------------
    task automatic endTest(input int idx, input string label);
        testCount++;
        if (testFails == 0) begin
            $display("entry %0d %s passed", idx, label);
        end else begin
            $display("entry %0d %s failed with %0d mismatches", idx, label, testFails);
        end
        testFails = 0;
    endtask

    function automatic int totalFails();
        return failCount + readyErrors;
    endfunction

    task automatic report();
        $display("%0d entries, %0d checks, %0d failures",
                 testCount, checkCount, totalFails());
    endtask

endmodule

// File: hw/DebugSubsystem.sv
`timescale 1ns/1ns

module DebugSubsystem #(
    parameter int BOOT_CYCLES = 20,
    parameter int MEM_DEPTH   = 256
) (
    input  logic            i_clk,
    input  logic            i_reset,
    // JTAG pins.
    input  logic            i_TCK,
    input  logic            i_TMS,
    input  logic            i_TDI,
    output logic            o_TDO,
    // Core memory port.
    input  logic            i_coreEn,
    input  logic            i_coreWr,
    input  DebugPkg::addr_t i_coreAddr,
    input  DebugPkg::data_t i_coreWrData,
    output DebugPkg::data_t o_coreRdData,
    output logic            o_coreReady,
    // MCU status.
    output logic            o_isBooted,
    output logic            o_isPaused,
    // Storage and boundary-scan enables.
    output logic            o_storeEn,
    output logic            o_scanEn,
    output logic            o_scanShift
);

    // Pause request from JTAG to run control.
    logic doPause;

    // JTAG side of the shared memory.
    MemReqIf jtagMem ();

    // --------------------
    // JTAG port.
    // --------------------
    JtagPort jtag_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_TCK       (i_TCK),
        .i_TMS       (i_TMS),
        .i_TDI       (i_TDI),
        .o_TDO       (o_TDO),
        .i_isBooted  (o_isBooted),
        .i_isPaused  (o_isPaused),
        .memReq      (jtagMem.requester),
        .o_storeEn   (o_storeEn),
        .o_scanEn    (o_scanEn),
        .o_scanShift (o_scanShift),
        .o_doPause   (doPause)
    );

    // --------------------
    // Run control.
    // --------------------
    McuRunControl #(
        .BOOT_CYCLES (BOOT_CYCLES)
    ) runCtrl_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_doPause   (doPause),
        .o_isBooted  (o_isBooted),
        .o_isPaused  (o_isPaused),
        .o_coreReady (o_coreReady)
    );

    // Shared scratch memory.
    DebugMemory #(
        .MEM_DEPTH (MEM_DEPTH)
    ) mem_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .jtagReq      (jtagMem.responder),
        .i_coreEn     (i_coreEn),
        .i_coreWr     (i_coreWr),
        .i_coreAddr   (i_coreAddr),
        .i_coreWrData (i_coreWrData),
        .o_coreRdData (o_coreRdData)
    );

endmodule

// File: hw/DebugMemory.sv
`timescale 1ns/1ns

module DebugMemory #(
    parameter int MEM_DEPTH = 256
) (
    input  logic            i_clk,
    input  logic            i_reset,
    // Requests from the JTAG port.
    MemReqIf.responder      jtagReq,
    // Core-side port.
    input  logic            i_coreEn,
    input  logic            i_coreWr,
    input  DebugPkg::addr_t i_coreAddr,
    input  DebugPkg::data_t i_coreWrData,
    output DebugPkg::data_t o_coreRdData
);

    // Index bits, addresses wrap on the depth.
    localparam int ADDR_W = $clog2(MEM_DEPTH);

    DebugPkg::data_t   mem [MEM_DEPTH];

    // Shared RAM port.
    logic              ramEn;
    logic              ramWr;
    DebugPkg::addr_t   ramAddr;
    DebugPkg::data_t   ramWrData;
    logic [ADDR_W-1:0] ramIdx;

    // Read data held per requester.
    DebugPkg::data_t   jtagRdQ;
    DebugPkg::data_t   coreRdQ;

    // --------------------
    // Port select.
    // --------------------
    // JTAG wins, though both never request together.
    always_comb begin
        ramEn = jtagReq.en | i_coreEn;
        if (jtagReq.en) begin
            ramWr     = jtagReq.wr;
            ramAddr   = jtagReq.addr;
            ramWrData = jtagReq.wrData;
        end else begin
            ramWr     = i_coreWr;
            ramAddr   = i_coreAddr;
            ramWrData = i_coreWrData;
        end
    end

    assign ramIdx = ramAddr[ADDR_W-1:0];

    // --------------------
    // RAM array.
    // --------------------
    always_ff @(posedge i_clk) begin
        if (ramEn && ramWr) begin
            mem[ramIdx] <= ramWrData;
        end
    end

    // Read data returns to whichever side asked.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            jtagRdQ <= '0;
            coreRdQ <= '0;
        end else if (ramEn && !ramWr) begin
            if (jtagReq.en) begin
                jtagRdQ <= mem[ramIdx];
            end else begin
                coreRdQ <= mem[ramIdx];
            end
        end
    end

    assign jtagReq.rdData = jtagRdQ;
    assign o_coreRdData   = coreRdQ;

    // JTAG only requests while paused, the core only while running.
    noDualRequest: assert property (@(posedge i_clk) disable iff (i_reset)
        !(jtagReq.en && i_coreEn))
        else $error("JTAG and core requested memory in the same cycle");

endmodule

// File: hw/McuRunControl.sv
`timescale 1ns/1ns

module McuRunControl #(
    parameter int BOOT_CYCLES = 20
) (
    input  logic i_clk,
    input  logic i_reset,
    // Pause request from the JTAG port.
    input  logic i_doPause,
    output logic o_isBooted,
    output logic o_isPaused,
    // Core may issue memory requests only while this is high.
    output logic o_coreReady
);

    // Counter wide enough to reach BOOT_CYCLES.
    localparam int CNT_W = $clog2(BOOT_CYCLES + 1);

    DebugPkg::mcuState_e state;
    logic [CNT_W-1:0]    bootCnt;

    // --------------------
    // Run state machine.
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state   <= DebugPkg::BOOTING;
            bootCnt <= '0;
        end else begin
            case (state)
                DebugPkg::BOOTING: begin
                    // Leave boot after exactly BOOT_CYCLES cycles.
                    if (bootCnt == CNT_W'(BOOT_CYCLES - 1)) begin
                        state <= DebugPkg::RUNNING;
                    end else begin
                        bootCnt <= bootCnt + 1'b1;
                    end
                end
                DebugPkg::RUNNING: begin
                    if (i_doPause) begin
                        state <= DebugPkg::PAUSED;
                    end
                end
                DebugPkg::PAUSED: begin
                    if (!i_doPause) begin
                        state <= DebugPkg::RUNNING;
                    end
                end
                default: begin
                    state <= DebugPkg::BOOTING;
                end
            endcase
        end
    end

    // --------------------
    // Status outputs.
    // --------------------
    assign o_isBooted  = (state != DebugPkg::BOOTING);
    assign o_isPaused  = (state == DebugPkg::PAUSED);
    assign o_coreReady = (state == DebugPkg::RUNNING);

    // The JTAG side only asks for a pause once boot has finished.
    pauseAfterBoot: assert property (@(posedge i_clk) disable iff (i_reset)
        !o_isBooted |-> !i_doPause)
        else $error("Pause requested while the MCU is still booting");

endmodule

// File: hw/JtagPort.sv
`timescale 1ns/1ns

module JtagPort (
    input  logic       i_clk,
    input  logic       i_reset,
    // Host pins, asynchronous to i_clk.
    input  logic       i_TCK,
    input  logic       i_TMS,
    input  logic       i_TDI,
    output logic       o_TDO,
    // MCU state for status and command gating.
    input  logic       i_isBooted,
    input  logic       i_isPaused,
    // Memory requests toward DebugMemory.
    MemReqIf.requester memReq,
    // Resource lock outputs.
    output logic       o_storeEn,
    output logic       o_scanEn,
    output logic       o_scanShift,
    // Run/pause request to McuRunControl.
    output logic       o_doPause
);

    // Pin synchronizers and TCK edge detect.
    logic [1:0] tckSync;
    logic [1:0] tmsSync;
    logic [1:0] tdiSync;
    logic       tckPrev;
    logic       tckRise;
    logic       tms;
    logic       tdi;

    // TAP state.
    DebugPkg::tapState_e tapState;
    DebugPkg::tapState_e tapNext;
    logic                execPulse;
    logic                inDShift;

    // JTAG registers.
    DebugPkg::instr_t iReg;
    DebugPkg::data_t  dReg;
    DebugPkg::addr_t  addrReg;
    logic             rdPending;

    // Decoded instruction.
    logic isAddrCmd;
    logic isRdCmd;
    logic isWrCmd;
    logic isScanCmd;
    logic isStoreCmd;
    logic isRunCmd;
    logic isPauseCmd;

    // Locks and gating.
    logic inControl;
    logic memEn;
    logic scanLock;
    logic storeLock;
    logic pauseReg;

    // --------------------
    // Pin synchronizers.
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            tckSync <= '0;
            tmsSync <= '0;
            tdiSync <= '0;
            tckPrev <= 1'b0;
        end else begin
            tckSync <= {tckSync[0], i_TCK};
            tmsSync <= {tmsSync[0], i_TMS};
            tdiSync <= {tdiSync[0], i_TDI};
            tckPrev <= tckSync[1];
        end
    end

    // One-cycle strobe per TCK rising edge, acts as the TAP clock enable.
    assign tckRise = tckSync[1] & ~tckPrev;
    assign tms     = tmsSync[1];
    assign tdi     = tdiSync[1];

    // --------------------
    // TAP state machine.
    // --------------------
    always_comb begin
        case (tapState)
            DebugPkg::IDLE:   tapNext = tms ? DebugPkg::IDLE   : DebugPkg::ISEL;
            DebugPkg::ISEL:   tapNext = tms ? DebugPkg::DSEL   : DebugPkg::ISHFT;
            DebugPkg::DSEL:   tapNext = tms ? DebugPkg::IDLE   : DebugPkg::DSHFT;
            DebugPkg::ISHFT:  tapNext = tms ? DebugPkg::UPDATE : DebugPkg::ISHFT;
            DebugPkg::DSHFT:  tapNext = tms ? DebugPkg::IDLE   : DebugPkg::DSHFT;
            // UPDATE always falls back to idle.
            default:          tapNext = DebugPkg::IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            tapState  <= DebugPkg::IDLE;
            execPulse <= 1'b0;
        end else begin
            // Fires in the first cycle spent in UPDATE.
            execPulse <= tckRise && (tapNext == DebugPkg::UPDATE)
                         && (tapState != DebugPkg::UPDATE);
            if (tckRise) begin
                tapState <= tapNext;
            end
        end
    end

    assign inDShift = (tapState == DebugPkg::DSHFT);

    // --------------------
    // Instruction register.
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            iReg <= '0;
        end else if (tckRise) begin
            if (tapState == DebugPkg::ISEL && !tms) begin
                // Status snapshot, paused above booted.
                iReg <= {6'b0, i_isPaused, i_isBooted};
            end else if (tapState == DebugPkg::ISHFT) begin
                // Includes the edge that leaves ISHFT.
                iReg <= {iReg[6:0], tdi};
            end
        end
    end

    // --------------------
    // Data register.
    // --------------------
    always_ff @(posedge i_clk) begin
        if (rdPending) begin
            dReg <= memReq.rdData;
        end else if (tckRise && inDShift) begin
            dReg <= {dReg[14:0], tdi};
        end
    end

    // Read data is captured the cycle after the request.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rdPending <= 1'b0;
        end else begin
            rdPending <= memEn && isRdCmd;
        end
    end

    // --------------------
    // Command decode.
    // --------------------
    always_comb begin
        isAddrCmd  = 1'b0;
        isRdCmd    = 1'b0;
        isWrCmd    = 1'b0;
        isScanCmd  = 1'b0;
        isStoreCmd = 1'b0;
        isRunCmd   = 1'b0;
        isPauseCmd = 1'b0;
        case (iReg)
            // Nothing to do, locks still drop on execute.
            DebugPkg::CMD_NOP:     isAddrCmd  = 1'b0;
            DebugPkg::CMD_SETADDR: isAddrCmd  = 1'b1;
            DebugPkg::CMD_RDMEM:   isRdCmd    = 1'b1;
            DebugPkg::CMD_WRMEM:   isWrCmd    = 1'b1;
            DebugPkg::CMD_BSCAN:   isScanCmd  = 1'b1;
            DebugPkg::CMD_STORE:   isStoreCmd = 1'b1;
            DebugPkg::CMD_RUN:     isRunCmd   = 1'b1;
            DebugPkg::CMD_PAUSE:   isPauseCmd = 1'b1;
            // Unknown codes are ignored.
            default:               isAddrCmd  = 1'b0;
        endcase
    end

    // Memory and lock commands need a booted, paused MCU.
    assign inControl = i_isBooted & i_isPaused;
    assign memEn     = execPulse & (isRdCmd | isWrCmd) & inControl;

    // --------------------
    // Address, locks and pause.
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            addrReg   <= '0;
            scanLock  <= 1'b0;
            storeLock <= 1'b0;
            pauseReg  <= 1'b0;
        end else if (execPulse) begin
            // Every execute re-evaluates both locks.
            scanLock  <= isScanCmd && inControl;
            storeLock <= isStoreCmd && inControl;
            if (isAddrCmd) begin
                addrReg <= dReg;
            end
            // Run and pause only once booted.
            if ((isRunCmd || isPauseCmd) && i_isBooted) begin
                pauseReg <= isPauseCmd;
            end
        end
    end

    // --------------------
    // Outputs.
    // --------------------
    assign memReq.en     = memEn;
    assign memReq.wr     = isWrCmd;
    assign memReq.addr   = addrReg;
    assign memReq.wrData = dReg;

    // Data MSB while shifting data, instruction MSB otherwise.
    assign o_TDO = inDShift ? dReg[15] : iReg[7];

    // Scan lock yields while a memory request is on the bus.
    assign o_scanEn    = scanLock & ~memEn;
    assign o_scanShift = scanLock & inDShift;
    assign o_storeEn   = storeLock & inDShift;
    assign o_doPause   = pauseReg;

    // A request needs a paused MCU with the pause request still standing.
    memReqPaused: assert property (@(posedge i_clk) disable iff (i_reset)
        memReq.en |-> i_isPaused && o_doPause)
        else $error("JTAG memory request while the MCU is not held paused");

endmodule

// File: hw/MemReqIf.sv
`timescale 1ns/1ns

// One memory requester into DebugMemory.
// A request is a single-cycle en pulse, writes land in that cycle.
// Read data shows up on rdData one cycle later.
interface MemReqIf;

    // Request strobe, one cycle wide.
    logic en;
    // High for write, low for read.
    logic wr;
    // Word address, wraps on the RAM depth.
    DebugPkg::addr_t addr;
    // Write payload.
    DebugPkg::data_t wrData;
    // Read payload, returned by the memory.
    DebugPkg::data_t rdData;

    // Side that issues requests.
    modport requester (
        output en,
        output wr,
        output addr,
        output wrData,
        input  rdData
    );

    // Side that serves requests.
    modport responder (
        input  en,
        input  wr,
        input  addr,
        input  wrData,
        output rdData
    );

endinterface

// File: hw/DebugPkg.sv
package DebugPkg;

    // --------------------
    // Widths with a meaning.
    // --------------------

    // Memory address as seen by both requesters.
    typedef logic [15:0] addr_t;

    // Memory word and JTAG data register.
    typedef logic [15:0] data_t;

    // JTAG instruction register, also carries the status bits.
    typedef logic [7:0] instr_t;

    // --------------------
    // State machines.
    // --------------------

    // TAP states, encoded to match the host-side documentation.
    typedef enum logic [2:0] {
        IDLE   = 3'b000,
        ISEL   = 3'b001,
        DSEL   = 3'b101,
        ISHFT  = 3'b100,
        DSHFT  = 3'b010,
        UPDATE = 3'b110
    } tapState_e;

    // Run state of the MCU.
    typedef enum logic [1:0] {
        BOOTING = 2'd0,
        RUNNING = 2'd1,
        PAUSED  = 2'd2
    } mcuState_e;

    // --------------------
    // JTAG command codes.
    // --------------------
    localparam instr_t CMD_NOP     = 8'h00;
    localparam instr_t CMD_SETADDR = 8'h01;
    localparam instr_t CMD_RDMEM   = 8'h02;
    localparam instr_t CMD_WRMEM   = 8'h03;
    localparam instr_t CMD_BSCAN   = 8'h04;
    localparam instr_t CMD_STORE   = 8'h05;
    localparam instr_t CMD_RUN     = 8'h06;
    localparam instr_t CMD_PAUSE   = 8'h07;

endpackage
